// ==== files.f ====
hdl/lsu_mem_pkg.sv
hdl/lsu_ctrl_pkg.sv
hdl/lsu_request_path.sv
hdl/lsu_load_extract.sv
hdl/lsu_request_fsm.sv
hdl/lsu_top.sv
test/lsu_tb.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - hdl/lsu_mem_pkg.sv
  - hdl/lsu_ctrl_pkg.sv
  - hdl/lsu_request_path.sv
  - hdl/lsu_load_extract.sv
  - hdl/lsu_request_fsm.sv
  - hdl/lsu_top.sv
  - target: test
    files:
      - test/lsu_tb.sv

// ==== test/lsu_tb.sv ====
//////////////////////////////////////////////////////////////////////
// load/store unit testbench
// random aligned loads and stores through a 64-word memory with
// random grant and response latency and execute stalls at the grant,
// checked against a lane-by-lane reference model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module lsu_tb;

  logic                    clk;
  logic                    rst_n;
  logic                    req;                // execute side request
  logic                    we;
  lsu_mem_pkg::data_type_e data_type;
  lsu_mem_pkg::sign_ext_e  sign_ext;
  logic [1:0]              reg_off;
  logic [31:0]             wdata;
  logic [31:0]             opa;
  logic [31:0]             opb;
  logic                    useincr;
  logic                    ex_valid;
  logic                    gnt;                // responder handshake
  logic                    rvalid;
  logic [31:0]             rdata_in;
  logic [31:0]             rdata_ex;           // DUT outputs
  logic [31:0]             addr;
  logic [31:0]             mem_wdata;
  logic [3:0]              be;
  logic                    ready_ex;
  logic                    ready_wb;
  logic                    busy;
  logic                    mem_req;
  logic                    mem_we;

  logic [31:0] mem [64];      // responder memory written from the DUT bus
  logic [31:0] ref_mem [64];  // model memory written by the model
  logic [31:0] last_load;     // expected held load result
  logic [31:0] lfsr;

  lsu_top UUT (
    .clk (clk), .rst_n (rst_n),
    .data_req_ex_i (req), .data_we_ex_i (we),
    .data_type_ex_i (data_type), .data_wdata_ex_i (wdata),
    .data_reg_offset_ex_i (reg_off), .data_sign_ext_ex_i (sign_ext),
    .operand_a_ex_i (opa), .operand_b_ex_i (opb),
    .addr_useincr_ex_i (useincr), .ex_valid_i (ex_valid),
    .data_rdata_ex_o (rdata_ex), .lsu_ready_ex_o (ready_ex),
    .lsu_ready_wb_o (ready_wb), .busy_o (busy),
    .data_req_o (mem_req), .data_addr_o (addr), .data_we_o (mem_we),
    .data_be_o (be), .data_wdata_o (mem_wdata),
    .data_gnt_i (gnt), .data_rvalid_i (rvalid), .data_rdata_i (rdata_in)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #20 clk = ~clk;  // 40 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // random source and reference model

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);  // galois form shifting right
  endfunction

  // one lfsr step for each bit taken with new bits entering at the lsb
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return r;
  endfunction

  // lanes touched by the first part of an access
  function automatic logic [3:0] lane_enables(logic [1:0] size, logic [1:0] off);
    for (int l = 0; l < 4; l++)
      case (size)
        2'd0:    lane_enables[l] = (l >= off);
        2'd1:    lane_enables[l] = (l == off) || (l == off + 1);
        default: lane_enables[l] = (l == off);
      endcase
  endfunction

  // lane l of the bus carries register lane (l - sh) mod 4
  function automatic logic [31:0] rotate_lanes(logic [31:0] d, logic [1:0] sh);
    for (int l = 0; l < 4; l++)
      rotate_lanes[8*l +: 8] = d[8*((l - sh) & 3) +: 8];
  endfunction

  function automatic logic [31:0] extend_load(logic [31:0] w, logic [1:0] size,
                                              logic [1:0] off, logic [1:0] ext);
    logic [31:0] field;
    int          bits;
    bits  = (size == 2'd0) ? 32 : (size == 2'd1) ? 16 : 8;
    field = w >> (8 * off);  // addressed lane down to bit 0
    for (int i = 0; i < 32; i++)
      if (i >= bits)
        field[i] = (ext == 2'd0) ? 1'b0 : (ext == 2'd2) ? 1'b1 : field[bits-1];
    return field;
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("FAIL at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic stop_on_timeout(string what);
    $display("timed out waiting for %s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // one access from request to idle

  task automatic run_access();
    logic [31:0] target;
    logic [31:0] b;
    logic [31:0] d;
    logic [31:0] rot;
    logic [31:0] exp_data;
    logic [3:0]  mbe;
    logic [5:0]  idx;
    logic [1:0]  size;
    logic [1:0]  off;
    logic [1:0]  roff;
    logic [1:0]  ext;
    logic        store;
    logic        incr;
    int          gdly;
    int          rdly;
    int          stall;
    int          k;

    store = rand_bits(1);
    size  = rand_bits(2);
    ext   = rand_bits(2);
    roff  = rand_bits(2);
    incr  = rand_bits(1);
    idx   = rand_bits(6);
    off   = rand_bits(2);
    if (size == 2'd0)
      off = 2'd0;     // words aligned
    else if (size == 2'd1)
      off[0] = 1'b0;  // halfwords on even lanes
    target   = (rand_bits(24) << 8) | {idx, off};  // upper bits are don't care to the memory
    b        = rand_bits(32);
    d        = rand_bits(32);
    gdly     = rand_bits(2);          // 0..3 cycles before the grant
    rdly     = 1 + rand_bits(2) % 3;  // 1..3 cycles to the response
    stall    = rand_bits(2) % 3;      // execute low for 0..2 cycles from the grant
    mbe      = lane_enables(size, off);
    rot      = rotate_lanes(d, off - roff);
    exp_data = '0;

    @(posedge clk);
    req       <= 1'b1;
    we        <= store;
    data_type <= lsu_mem_pkg::data_type_e'(size);
    sign_ext  <= lsu_mem_pkg::sign_ext_e'(ext);
    reg_off   <= roff;
    wdata     <= d;
    opa       <= incr ? target - b : target;
    opb       <= b;
    useincr   <= incr;
    for (int t = 0; t < gdly; t++)
    begin
      @(negedge clk);
      check_value("data_req_o", 1, mem_req);  // held until granted
      check_value("lsu_ready_ex_o", 0, ready_ex);
      check_value("busy_o", 1, busy);
      @(posedge clk);
    end
    gnt      <= 1'b1;
    ex_valid <= (stall == 0);
    @(negedge clk);
    check_value("data_req_o", 1, mem_req);
    check_value("lsu_ready_ex_o", 1, ready_ex);
    check_value("data_addr_o", target, addr);
    check_value("data_we_o", store, mem_we);
    if (store)
    begin
      check_value("data_be_o", mbe, be);
      check_value("data_wdata_o", rot, mem_wdata);
      for (int l = 0; l < 4; l++)
      begin
        if (be[l])
          mem[idx][8*l +: 8] = mem_wdata[8*l +: 8];
        if (mbe[l])
          ref_mem[idx][8*l +: 8] = rot[8*l +: 8];
      end
    end
    else
      exp_data = extend_load(ref_mem[idx], size, off, ext);

    // response and stall phase that ends once the unit is idle again
    k = 0;
    do
    begin
      k++;
      if (k > 8)
        stop_on_timeout("the unit to go idle after the response");
      @(posedge clk);
      gnt      <= 1'b0;
      rvalid   <= (k == rdly);
      rdata_in <= mem[idx];
      ex_valid <= (k >= stall);
      req      <= (k < stall);  // next request pending behind the stall
      @(negedge clk);
      if (k == rdly)
      begin
        if (!store)
        begin
          check_value("data_rdata_ex_o", exp_data, rdata_ex);  // live value
          last_load = exp_data;
        end
      end
      else
        check_value("data_rdata_ex_o", last_load, rdata_ex);  // held copy
      if (k < rdly)
      begin
        check_value("busy_o", 1, busy);
        check_value("lsu_ready_wb_o", k <= stall, ready_wb);  // high only in stall states
      end
      if (k < stall)
        check_value("data_req_o", 0, mem_req);
    end
    while (k <= rdly || busy);
    check_value("data_req_o", 0, mem_req);
    check_value("lsu_ready_wb_o", 1, ready_wb);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence

  initial
  begin
    lfsr      = 32'h3f87_ea6d;
    last_load = 32'h0;
    rst_n     = 1'b0;
    req       = 1'b0;
    we        = 1'b0;
    data_type = lsu_mem_pkg::WORD;
    sign_ext  = lsu_mem_pkg::ZERO_EXT;
    reg_off   = 2'd0;
    wdata     = 32'h0;
    opa       = 32'h0;
    opb       = 32'h0;
    useincr   = 1'b0;
    ex_valid  = 1'b1;
    gnt       = 1'b0;
    rvalid    = 1'b0;
    rdata_in  = 32'h0;
    for (int i = 0; i < 64; i++)
    begin
      mem[i]     = (i + 1) * 32'h9e37_79b9;  // every word differs
      ref_mem[i] = mem[i];
    end
    repeat (4)
      @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("busy_o", 0, busy);  // quiet after reset
    check_value("data_req_o", 0, mem_req);
    check_value("lsu_ready_wb_o", 1, ready_wb);
    check_value("data_rdata_ex_o", 0, rdata_ex);
    for (int n = 0; n < 300; n++)
      run_access();
    $display("Test passed");
    $finish;
  end

endmodule

// ==== hdl/lsu_top.sv ====
//////////////////////////////////////////////////////////////////////
// load/store unit top level
// connects the execute stage to a request / grant / rvalid data
// memory port through the request path, load extraction and FSM
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module lsu_top
(
  input  logic                    clk,
  input  logic                    rst_n,

  // execute stage
  input  logic                    data_req_ex_i,
  input  logic                    data_we_ex_i,
  input  lsu_mem_pkg::data_type_e data_type_ex_i,
  input  lsu_mem_pkg::word_t      data_wdata_ex_i,
  input  lsu_mem_pkg::offset_t    data_reg_offset_ex_i,
  input  lsu_mem_pkg::sign_ext_e  data_sign_ext_ex_i,
  input  lsu_mem_pkg::word_t      operand_a_ex_i,
  input  lsu_mem_pkg::word_t      operand_b_ex_i,
  input  logic                    addr_useincr_ex_i,
  input  logic                    ex_valid_i,

  output lsu_mem_pkg::word_t      data_rdata_ex_o,
  output logic                    lsu_ready_ex_o,
  output logic                    lsu_ready_wb_o,
  output logic                    busy_o,

  // data memory
  output logic                    data_req_o,
  output lsu_mem_pkg::word_t      data_addr_o,
  output logic                    data_we_o,
  output lsu_mem_pkg::be_t        data_be_o,
  output lsu_mem_pkg::word_t      data_wdata_o,
  input  logic                    data_gnt_i,
  input  logic                    data_rvalid_i,
  input  lsu_mem_pkg::word_t      data_rdata_i
);

  lsu_mem_pkg::offset_t addr_offset;  // lane of the current request

  assign addr_offset = data_addr_o[lsu_mem_pkg::OFFSET_W-1:0];
  assign data_we_o   = data_we_ex_i;  // direction goes straight out

  lsu_request_path u_request_path (
    .operand_a_i    (operand_a_ex_i),
    .operand_b_i    (operand_b_ex_i),
    .addr_useincr_i (addr_useincr_ex_i),
    .data_type_i    (data_type_ex_i),
    .wdata_i        (data_wdata_ex_i),
    .reg_offset_i   (data_reg_offset_ex_i),
    .addr_o         (data_addr_o),
    .be_o           (data_be_o),
    .wdata_o        (data_wdata_o)
  );

  lsu_load_extract u_load_extract (
    .clk            (clk),
    .rst_n          (rst_n),
    .gnt_i          (data_gnt_i),
    .we_i           (data_we_ex_i),
    .data_type_i    (data_type_ex_i),
    .sign_ext_i     (data_sign_ext_ex_i),
    .addr_offset_i  (addr_offset),
    .rvalid_i       (data_rvalid_i),
    .rdata_i        (data_rdata_i),
    .rdata_o        (data_rdata_ex_o)
  );

  lsu_request_fsm u_request_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (data_req_ex_i),
    .gnt_i          (data_gnt_i),
    .rvalid_i       (data_rvalid_i),
    .ex_valid_i     (ex_valid_i),
    .data_req_o     (data_req_o),
    .ready_ex_o     (lsu_ready_ex_o),
    .ready_wb_o     (lsu_ready_wb_o),
    .busy_o         (busy_o)
  );

endmodule

// ==== hdl/lsu_request_fsm.sv ====
//////////////////////////////////////////////////////////////////////
// load/store unit request controller
// issues memory requests for the execute stage, keeps at most one
// response outstanding, tracks execute stalls across a grant and
// drives the ready and busy status toward the pipeline
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module lsu_request_fsm
(
  input  logic clk,
  input  logic rst_n,

  input  logic req_i,        // execute stage wants an access
  input  logic gnt_i,        // memory grant
  input  logic rvalid_i,     // memory response
  input  logic ex_valid_i,   // execute stage advances this cycle

  output logic data_req_o,   // request to memory
  output logic ready_ex_o,   // execute may move on
  output logic ready_wb_o,   // writeback may move on
  output logic busy_o        // anything in flight
);

  lsu_ctrl_pkg::lsu_state_e state_q;
  lsu_ctrl_pkg::lsu_state_e next_state;
  lsu_ctrl_pkg::lsu_state_e issue_state;  // target after a grant

  // a grant while execute is stalled must not let the next request out
  assign issue_state = ex_valid_i ? lsu_ctrl_pkg::WAIT_RVALID
                                  : lsu_ctrl_pkg::WAIT_RVALID_EX_STALL;

  //////////////////////////////////////////////////////////////////////
  // state register

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= lsu_ctrl_pkg::IDLE;
    else
      state_q <= next_state;
  end

  //////////////////////////////////////////////////////////////////////
  // next state and outputs

  always_comb
  begin
    next_state = state_q;
    data_req_o = 1'b0;
    ready_ex_o = 1'b1;
    ready_wb_o = 1'b1;

    case (state_q)
      lsu_ctrl_pkg::IDLE:
      begin
        data_req_o = req_i;
        if (req_i)
        begin
          ready_ex_o = gnt_i;  // hold execute until granted
          if (gnt_i)
            next_state = issue_state;
        end
      end

      lsu_ctrl_pkg::WAIT_RVALID:
      begin
        ready_wb_o = rvalid_i;  // writeback waits for the data
        if (rvalid_i)
        begin
          // response frees the port, back-to-back issue allowed
          data_req_o = req_i;
          if (req_i)
            ready_ex_o = gnt_i;
          if (req_i && gnt_i)
            next_state = issue_state;
          else
            next_state = lsu_ctrl_pkg::IDLE;  // ungranted request retried from IDLE
        end
      end

      lsu_ctrl_pkg::WAIT_RVALID_EX_STALL:
      begin
        // no new requests here, the pending one is for a stalled instr
        if (rvalid_i)
        begin
          if (ex_valid_i)
            next_state = lsu_ctrl_pkg::IDLE;
          else
            next_state = lsu_ctrl_pkg::IDLE_EX_STALL;
        end
        else if (ex_valid_i)
        begin
          next_state = lsu_ctrl_pkg::WAIT_RVALID;  // stall over, normal wait
        end
      end

      lsu_ctrl_pkg::IDLE_EX_STALL:
      begin
        if (ex_valid_i)
          next_state = lsu_ctrl_pkg::IDLE;
      end

      default:
      begin
        next_state = lsu_ctrl_pkg::IDLE;
      end
    endcase
  end

  assign busy_o = (state_q != lsu_ctrl_pkg::IDLE) || data_req_o;

endmodule

// ==== hdl/lsu_load_extract.sv ====
//////////////////////////////////////////////////////////////////////
// load/store unit load data extraction
// remembers the format of the granted access, then pulls the
// addressed byte or halfword out of the response word and fills
// the upper bits with zeros, the sign bit or ones; the last load
// result is held for a stalled writeback
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module lsu_load_extract
(
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    gnt_i,          // memory accepted the request
  input  logic                    we_i,           // store when high
  input  lsu_mem_pkg::data_type_e data_type_i,    // size of the request in flight
  input  lsu_mem_pkg::sign_ext_e  sign_ext_i,     // fill mode of the request
  input  lsu_mem_pkg::offset_t    addr_offset_i,  // low address bits of the request

  input  logic                    rvalid_i,       // response cycle
  input  lsu_mem_pkg::word_t      rdata_i,        // raw memory word

  output lsu_mem_pkg::word_t      rdata_o         // extended load data to the core
);

  // format of the access that is waiting for its response
  lsu_mem_pkg::data_type_e data_type_q;
  lsu_mem_pkg::sign_ext_e  sign_ext_q;
  lsu_mem_pkg::offset_t    rdata_offset_q;
  logic                    we_q;

  logic [lsu_mem_pkg::HALF_W-1:0] half_sel;  // addressed halfword
  logic [lsu_mem_pkg::BYTE_W-1:0] byte_sel;  // addressed byte
  lsu_mem_pkg::word_t             rdata_ext; // live extended result
  lsu_mem_pkg::word_t             rdata_q;   // last load result

  // value of the bits above the loaded field
  function automatic logic fill_bit(lsu_mem_pkg::sign_ext_e mode, logic msb);
    case (mode)
      lsu_mem_pkg::ZERO_EXT: fill_bit = 1'b0;
      lsu_mem_pkg::ONE_EXT:  fill_bit = 1'b1;
      default:               fill_bit = msb;  // SIGN_EXT and code 3
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // access format capture

  // a grant means the execute inputs belong to the access whose
  // response comes next
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      data_type_q    <= lsu_mem_pkg::WORD;
      sign_ext_q     <= lsu_mem_pkg::ZERO_EXT;
      rdata_offset_q <= '0;
      we_q           <= 1'b0;
    end
    else if (gnt_i)
    begin
      data_type_q    <= data_type_i;
      sign_ext_q     <= sign_ext_i;
      rdata_offset_q <= addr_offset_i;
      we_q           <= we_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // lane selection

  // offset 3 is the misaligned case, low byte comes from the held word
  always_comb
  begin
    case (rdata_offset_q)
      2'd0:    half_sel = rdata_i[15:0];
      2'd1:    half_sel = rdata_i[23:8];
      2'd2:    half_sel = rdata_i[31:16];
      default: half_sel = {rdata_i[7:0], rdata_q[31:24]};
    endcase
  end

  assign byte_sel = rdata_i[rdata_offset_q*lsu_mem_pkg::BYTE_W +: lsu_mem_pkg::BYTE_W];

  //////////////////////////////////////////////////////////////////////
  // extension

  always_comb
  begin
    case (data_type_q)
      lsu_mem_pkg::WORD:
      begin
        rdata_ext = rdata_i;  // words pass through
      end
      lsu_mem_pkg::HALF:
      begin
        rdata_ext = {{16{fill_bit(sign_ext_q, half_sel[15])}}, half_sel};
      end
      default:
      begin
        rdata_ext = {{24{fill_bit(sign_ext_q, byte_sel[7])}}, byte_sel};
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // held result

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      rdata_q <= '0;
    end
    else if (rvalid_i && !we_q)  // store responses leave it alone
    begin
      rdata_q <= rdata_ext;
    end
  end

  // live value in the response cycle, held copy afterwards
  assign rdata_o = rvalid_i ? rdata_ext : rdata_q;

endmodule

// ==== hdl/lsu_request_path.sv ====
//////////////////////////////////////////////////////////////////////
// load/store unit request path
// forms the memory address from the execute operands, picks the
// byte enables for the access size and rotates store data into
// the addressed lanes, all purely combinational
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module lsu_request_path
(
  input  lsu_mem_pkg::word_t      operand_a_i,     // base register
  input  lsu_mem_pkg::word_t      operand_b_i,     // immediate or increment
  input  logic                    addr_useincr_i,  // 1: a + b, 0: a alone
  input  lsu_mem_pkg::data_type_e data_type_i,     // word / half / byte
  input  lsu_mem_pkg::word_t      wdata_i,         // store data as held in the register
  input  lsu_mem_pkg::offset_t    reg_offset_i,    // byte offset of the data in the register

  output lsu_mem_pkg::word_t      addr_o,          // to memory
  output lsu_mem_pkg::be_t        be_o,            // to memory
  output lsu_mem_pkg::word_t      wdata_o          // to memory, lane aligned
);

  lsu_mem_pkg::offset_t addr_offset;   // low address bits
  lsu_mem_pkg::offset_t wdata_offset;  // lanes to rotate store data by

  //////////////////////////////////////////////////////////////////////
  // address generation

  // post-increment style accesses use a alone
  assign addr_o      = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign addr_offset = addr_o[lsu_mem_pkg::OFFSET_W-1:0];

  //////////////////////////////////////////////////////////////////////
  // byte enables

  // only the first part of an access is generated, so a word at
  // offset 1 enables lanes 1..3 and nothing wraps into lane 0
  always_comb
  begin
    case (data_type_i)
      lsu_mem_pkg::WORD:
      begin
        be_o = lsu_mem_pkg::BE_WORD << addr_offset;  // 1111 1110 1100 1000
      end
      lsu_mem_pkg::HALF:
      begin
        be_o = lsu_mem_pkg::BE_HALF << addr_offset;  // 0011 0110 1100 1000
      end
      default:
      begin
        be_o = lsu_mem_pkg::BE_BYTE << addr_offset;  // one-hot lane, BYTE and BYTE_ALT
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // store data rotation

  // wraps mod 4, e.g. addr 3 with reg offset 1 moves data up two lanes
  assign wdata_offset = addr_offset - reg_offset_i;

  // rotate left by whole lanes
  always_comb
  begin
    case (wdata_offset)
      2'd0:    wdata_o = wdata_i;
      2'd1:    wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'd2:    wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      default: wdata_o = {wdata_i[7:0],  wdata_i[31:8]};
    endcase
  end

endmodule

// ==== hdl/lsu_ctrl_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// load/store unit request controller definitions
// state encoding of the grant / response tracking FSM
//////////////////////////////////////////////////////////////////////

package lsu_ctrl_pkg;

  // IDLE                  nothing outstanding
  // WAIT_RVALID           one access granted, response pending
  // WAIT_RVALID_EX_STALL  granted while execute was stalled
  // IDLE_EX_STALL         response in, execute still stalled
  typedef enum logic [1:0] {
    IDLE,
    WAIT_RVALID,
    WAIT_RVALID_EX_STALL,
    IDLE_EX_STALL
  } lsu_state_e;

endpackage

// ==== hdl/lsu_mem_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// load/store unit memory access definitions
// word, byte-enable and offset types, access size and load
// extension encodings, byte-lane constants for enable generation
//////////////////////////////////////////////////////////////////////

package lsu_mem_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths

  localparam int BYTES_PER_WORD = 4;                        // lanes per data word
  localparam int BYTE_W         = 8;                        // bits per lane
  localparam int HALF_W         = 2 * BYTE_W;               // halfword width
  localparam int WORD_W         = BYTES_PER_WORD * BYTE_W;  // data / address word
  localparam int OFFSET_W       = $clog2(BYTES_PER_WORD);   // byte offset inside a word

  //////////////////////////////////////////////////////////////////////
  // plain vector types

  typedef logic [WORD_W-1:0]         word_t;    // data or address word
  typedef logic [BYTES_PER_WORD-1:0] be_t;      // one enable per lane
  typedef logic [OFFSET_W-1:0]       offset_t;  // low address bits

  //////////////////////////////////////////////////////////////////////
  // encodings from the execute stage

  // access size, both 2 and 3 mean a byte
  typedef enum logic [1:0] {WORD = 2'd0, HALF = 2'd1, BYTE = 2'd2, BYTE_ALT = 2'd3}
    data_type_e;

  // load fill mode, the unnamed code 3 sign-extends like SIGN_EXT
  typedef enum logic [1:0] {ZERO_EXT = 2'd0, SIGN_EXT = 2'd1, ONE_EXT = 2'd2}
    sign_ext_e;

  //////////////////////////////////////////////////////////////////////
  // byte-lane patterns at offset 0

  // shifted left by the address offset these give the first-part
  // enable table, lanes above lane 3 simply fall off
  localparam be_t BE_WORD = 4'b1111;  // all four lanes
  localparam be_t BE_HALF = 4'b0011;  // two low lanes
  localparam be_t BE_BYTE = 4'b0001;  // lane 0 only

endpackage
